// ==== verilog/elk_mem_pkg.sv ====
// Memory subsystem types, region codes, array sizes and download index
`default_nettype none

package elk_mem_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Vector types
	////////////////////////////////////////////////////////////////////////////

	// CPU external address, A18..A0
	typedef logic [18:0] elk_addr_t;

	// Data byte on CPU and download side
	typedef logic [7:0] elk_byte_t;

	// ROM array address, slot in 16:14, offset below
	typedef logic [16:0] rom_addr_t;

	// RAM array address, bank in 16:14, offset below
	typedef logic [16:0] ram_addr_t;

	// Which array answers a CPU access
	typedef logic [1:0] mem_region_t;

	////////////////////////////////////////////////////////////////////////////
	// Region codes
	////////////////////////////////////////////////////////////////////////////

	// Hole in the map, reads zero
	localparam mem_region_t REGION_NONE = 2'd0;
	// One of the seven ROM slots
	localparam mem_region_t REGION_ROM  = 2'd1;
	// One of the eight sideways RAM banks
	localparam mem_region_t REGION_RAM  = 2'd2;

	////////////////////////////////////////////////////////////////////////////
	// Sizes of the fixed Electron map
	////////////////////////////////////////////////////////////////////////////

	// Offset bits inside one 16 KB bank
	localparam int BANK_BITS = 14;

	// Seven ROM slots of 16 KB
	localparam int ROM_WORDS = 7 * (1 << BANK_BITS);

	// Eight RAM banks of 16 KB
	localparam int RAM_WORDS = 8 * (1 << BANK_BITS);

	// Download image index that lands in ROM
	localparam elk_byte_t ROM_LOAD_INDEX = 8'd0;

endpackage

`default_nettype wire

// ==== verilog/elk_mem_decode.sv ====
// Address decoder: CPU address to ROM slot, RAM bank and region, plus RAM write pulse
`timescale 1ns/1ps
`default_nettype none

module elk_mem_decode import elk_mem_pkg::*; (
	input  wire         clk_sys,
	input  wire         arst_n,
	input  elk_addr_t   cpu_addr,
	input  wire         cpu_we_n,
	output rom_addr_t   rom_addr,
	output ram_addr_t   ram_addr,
	output mem_region_t region,
	output logic        ram_we
);

	// Slot number picked by the ROM half of the map
	logic [2:0] rom_slot;

	// Write strobe from the previous cycle
	logic we_n_q;

	////////////////////////////////////////////////////////////////////////////
	// Memory map
	////////////////////////////////////////////////////////////////////////////

	// Lower half holds ROM slots, upper half holds RAM and a hole
	always_comb begin
		rom_slot = 3'd0;
		region   = REGION_NONE;
		if (cpu_addr[18]) begin
			// 1_00_xx and 1_01_xx are RAM, 1_1x_xx is unmapped
			if (!cpu_addr[17]) begin
				region = REGION_RAM;
			end
		end else begin
			region = REGION_ROM;
			case (cpu_addr[17:14])
				// Single window slot
				4'b01_00: rom_slot = 3'd0;
				// OS image, seen through two windows
				4'b10_00,
				4'b10_01: rom_slot = 3'd1;
				// BASIC image, also twice
				4'b10_10,
				4'b10_11: rom_slot = 3'd2;
				4'b11_00: rom_slot = 3'd3;
				4'b11_01: rom_slot = 3'd4;
				4'b11_10: rom_slot = 3'd5;
				4'b11_11: rom_slot = 3'd6;
				// 0_00_xx and 0_01_01..0_01_11 are empty
				default: begin
					rom_slot = 3'd0;
					region   = REGION_NONE;
				end
			endcase
		end
	end

	// Offset is shared by every mapped window
	assign rom_addr = {rom_slot, cpu_addr[BANK_BITS-1:0]};

	// Bank number is the low three bits of the window
	assign ram_addr = {cpu_addr[16:14], cpu_addr[BANK_BITS-1:0]};

	////////////////////////////////////////////////////////////////////////////
	// RAM write pulse
	////////////////////////////////////////////////////////////////////////////

	// Idle high so no write fires straight out of reset
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			we_n_q <= 1'b1;
		end else begin
			we_n_q <= cpu_we_n;
		end
	end

	// First low cycle of the strobe only
	// ROM windows and the upper hole never write
	assign ram_we = (region == REGION_RAM) & we_n_q & ~cpu_we_n;

endmodule

`default_nettype wire

// ==== verilog/elk_mem_store.sv ====
// ROM array with download write port and sideways RAM array, both with registered address
`timescale 1ns/1ps
`default_nettype none

module elk_mem_store import elk_mem_pkg::*; (
	input  wire       clk_sys,
	input  rom_addr_t rom_addr,
	input  ram_addr_t ram_addr,
	input  wire       ram_we,
	input  elk_byte_t cpu_wdata,
	input  wire       load_en,
	input  wire       load_wr,
	input  elk_byte_t load_index,
	input  rom_addr_t load_addr,
	input  elk_byte_t load_data,
	output elk_byte_t rom_q,
	output elk_byte_t ram_q
);

	// Seven 16 KB ROM images
	elk_byte_t rom_mem [0:ROM_WORDS-1];
	// Eight 16 KB RAM banks
	elk_byte_t ram_mem [0:RAM_WORDS-1];

	// Address registers of the two arrays
	rom_addr_t rom_addr_q;
	ram_addr_t ram_addr_q;

	// ROM port address, download side wins in load mode
	rom_addr_t rom_port_addr;

	// Download byte aimed at the ROM image
	logic rom_wr;

	// Blank arrays at power up, images arrive over the download port
	initial begin
		for (int i = 0; i < ROM_WORDS; i++) begin
			rom_mem[i] = '0;
		end
		for (int i = 0; i < RAM_WORDS; i++) begin
			ram_mem[i] = '0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// ROM
	////////////////////////////////////////////////////////////////////////////

	assign rom_port_addr = load_en ? load_addr : rom_addr;

	// Other image indices belong to other loaders
	assign rom_wr = load_en & load_wr & (load_index == ROM_LOAD_INDEX);

	always_ff @(posedge clk_sys) begin
		rom_addr_q <= rom_port_addr;
		if (rom_wr) begin
			rom_mem[rom_port_addr] <= load_data;
		end
	end

	// Read through the registered address, new data on a same-address write
	assign rom_q = rom_mem[rom_addr_q];

	////////////////////////////////////////////////////////////////////////////
	// RAM
	////////////////////////////////////////////////////////////////////////////

	// Load mode leaves the RAM alone
	always_ff @(posedge clk_sys) begin
		ram_addr_q <= ram_addr;
		if (ram_we) begin
			ram_mem[ram_addr] <= cpu_wdata;
		end
	end

	assign ram_q = ram_mem[ram_addr_q];

endmodule

`default_nettype wire

// ==== verilog/elk_mem_readback.sv ====
// Read data select: region aligned to array latency, ROM, RAM or zero
`timescale 1ns/1ps
`default_nettype none

module elk_mem_readback import elk_mem_pkg::*; (
	input  wire         clk_sys,
	input  wire         arst_n,
	input  mem_region_t region,
	input  elk_byte_t   rom_q,
	input  elk_byte_t   ram_q,
	output elk_byte_t   cpu_rdata
);

	// Region of the access now leaving the arrays
	mem_region_t region_q;

	// Same one-cycle delay as the array address registers
	// Clears to the hole so the bus reads zero after reset
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			region_q <= REGION_NONE;
		end else begin
			region_q <= region;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Data select
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (region_q)
			REGION_ROM: cpu_rdata = rom_q;
			REGION_RAM: cpu_rdata = ram_q;
			// Unmapped windows float to zero
			default:    cpu_rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/elk_mem_top.sv ====
// Memory subsystem top: decoder, ROM and RAM arrays, read data select
`timescale 1ns/1ps
`default_nettype none

module elk_mem_top import elk_mem_pkg::*; (
	input  wire       clk_sys,
	input  wire       arst_n,
	// CPU external bus
	input  elk_addr_t cpu_addr,
	input  wire       cpu_we_n,
	input  elk_byte_t cpu_wdata,
	output elk_byte_t cpu_rdata,
	// ROM download port
	input  wire       load_en,
	input  wire       load_wr,
	input  elk_byte_t load_index,
	input  rom_addr_t load_addr,
	input  elk_byte_t load_data
);

	// Decoder outputs
	rom_addr_t   rom_addr;
	ram_addr_t   ram_addr;
	mem_region_t region;
	logic        ram_we;

	// Array outputs, one cycle after the address
	elk_byte_t rom_q;
	elk_byte_t ram_q;

	////////////////////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////////////////////

	elk_mem_decode u_decode (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.cpu_addr (cpu_addr),
		.cpu_we_n (cpu_we_n),
		.rom_addr (rom_addr),
		.ram_addr (ram_addr),
		.region   (region),
		.ram_we   (ram_we)
	);

	////////////////////////////////////////////////////////////////////////////
	// Arrays
	////////////////////////////////////////////////////////////////////////////

	elk_mem_store u_store (
		.clk_sys    (clk_sys),
		.rom_addr   (rom_addr),
		.ram_addr   (ram_addr),
		.ram_we     (ram_we),
		.cpu_wdata  (cpu_wdata),
		.load_en    (load_en),
		.load_wr    (load_wr),
		.load_index (load_index),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.rom_q      (rom_q),
		.ram_q      (ram_q)
	);

	// Read data back to the CPU
	elk_mem_readback u_readback (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.region    (region),
		.rom_q     (rom_q),
		.ram_q     (ram_q),
		.cpu_rdata (cpu_rdata)
	);

endmodule

`default_nettype wire

// ==== test/elk_mem_chk.sv ====
// Concurrent assertions on write pulse, region and read data, bound into elk_mem_top
`timescale 1ns/1ps
`default_nettype none

module elk_mem_chk import elk_mem_pkg::*; (
	input wire         clk_sys,
	input wire         arst_n,
	input elk_addr_t   cpu_addr,
	input mem_region_t region,
	input wire         ram_we,
	input elk_byte_t   cpu_rdata
);

	////////////////////////////////////////////////////////////////////////////
	// Write pulse
	////////////////////////////////////////////////////////////////////////////

	// One pulse per strobe, never stretched
	assert property (@(posedge clk_sys) disable iff (!arst_n)
		ram_we |=> !ram_we)
		else $error("ram_we high in two consecutive cycles");

	// ROM windows and the holes never write, RAM lives at 1_0x_xx
	assert property (@(posedge clk_sys) disable iff (!arst_n)
		ram_we |-> cpu_addr[18:17] == 2'b10)
		else $error("ram_we outside the RAM region");

	////////////////////////////////////////////////////////////////////////////
	// Read data
	////////////////////////////////////////////////////////////////////////////

	// Unmapped access reads zero a cycle later
	assert property (@(posedge clk_sys) disable iff (!arst_n)
		region == REGION_NONE |=> cpu_rdata == '0)
		else $error("cpu_rdata not zero after an unmapped access");

	// Aligned region clears in reset
	assert property (@(posedge clk_sys)
		$rose(arst_n) |-> cpu_rdata == '0)
		else $error("cpu_rdata not zero in the first cycle after reset");

endmodule

bind elk_mem_top elk_mem_chk u_chk (
	.clk_sys   (clk_sys),
	.arst_n    (arst_n),
	.cpu_addr  (cpu_addr),
	.region    (region),
	.ram_we    (ram_we),
	.cpu_rdata (cpu_rdata)
);

`default_nettype wire

// ==== test/tb_elk_mem.sv ====
// Directed testbench: clock, reset, watchdog, memory model, compare task and test tasks
`timescale 1ns/1ps
`default_nettype none

module tb_elk_mem import elk_mem_pkg::*; ();

	// 100 ns clock
	localparam int HALF_PERIOD = 50;
	// Tests take about 260 cycles, roughly eight times that as margin
	localparam int WATCHDOG_CYCLES = 2000;

	// DUT inputs
	logic      clk_sys;
	logic      arst_n;
	elk_addr_t cpu_addr;
	logic      cpu_we_n;
	elk_byte_t cpu_wdata;
	logic      load_en;
	logic      load_wr;
	elk_byte_t load_index;
	rom_addr_t load_addr;
	elk_byte_t load_data;

	// DUT output
	elk_byte_t cpu_rdata;

	// Fixed seed for repeatable stimulus
	integer seed = 32'hae0f;

	// Model of the ROM images and RAM banks
	elk_byte_t rom_model [0:ROM_WORDS-1] = '{default: 8'h00};
	elk_byte_t ram_model [0:RAM_WORDS-1] = '{default: 8'h00};

	// Locations touched so far, reused by later tests
	rom_addr_t loaded_rom [$];
	elk_addr_t written_ram [$];

	elk_mem_top UUT (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.cpu_addr   (cpu_addr),
		.cpu_we_n   (cpu_we_n),
		.cpu_wdata  (cpu_wdata),
		.cpu_rdata  (cpu_rdata),
		.load_en    (load_en),
		.load_wr    (load_wr),
		.load_index (load_index),
		.load_addr  (load_addr),
		.load_data  (load_data)
	);

	initial begin
		clk_sys = 1'b0;
		forever #HALF_PERIOD clk_sys = ~clk_sys;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$fatal(1, "Watchdog expired");
	end

	////////////////////////////////////////////////////////////////////////////
	// Memory map model
	////////////////////////////////////////////////////////////////////////////

	// CPU window of a ROM slot, alt picks the second alias of slots 1 and 2
	function automatic logic [4:0] rom_window(input logic [2:0] slot, input logic alt);
		case (slot)
			3'd0: return 5'b0_01_00;
			3'd1: return alt ? 5'b0_10_01 : 5'b0_10_00;
			3'd2: return alt ? 5'b0_10_11 : 5'b0_10_10;
			3'd3: return 5'b0_11_00;
			3'd4: return 5'b0_11_01;
			3'd5: return 5'b0_11_10;
			3'd6: return 5'b0_11_11;
			default: return 5'b0_00_00;
		endcase
	endfunction

	function automatic elk_addr_t rom_cpu_addr(input rom_addr_t la, input logic alt);
		return {rom_window(la[16:14], alt), la[13:0]};
	endfunction

	// RAM sits at 1_0b_bb
	function automatic elk_addr_t ram_cpu_addr(input logic [2:0] bank, input logic [13:0] off);
		return {2'b10, bank, off};
	endfunction

	// Byte the CPU should see at an address
	function automatic elk_byte_t expected_read(input elk_addr_t a);
		logic [13:0] off;
		off = a[13:0];
		casez (a[18:14])
			5'b0_01_00: return rom_model[{3'd0, off}];
			5'b0_10_0?: return rom_model[{3'd1, off}];
			5'b0_10_1?: return rom_model[{3'd2, off}];
			5'b0_11_00: return rom_model[{3'd3, off}];
			5'b0_11_01: return rom_model[{3'd4, off}];
			5'b0_11_10: return rom_model[{3'd5, off}];
			5'b0_11_11: return rom_model[{3'd6, off}];
			5'b1_0?_??: return ram_model[{a[16:14], off}];
			// Holes in both halves
			default:    return 8'h00;
		endcase
	endfunction

	// Only RAM windows take CPU writes
	function automatic void model_write(input elk_addr_t a, input elk_byte_t d);
		if (a[18:17] == 2'b10) begin
			ram_model[{a[16:14], a[13:0]}] = d;
		end
	endfunction

	function automatic elk_byte_t rand_byte();
		integer r;
		r = $random(seed);
		return r[7:0];
	endfunction

	function automatic logic [13:0] rand_offset();
		integer r;
		r = $random(seed);
		return r[13:0];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Bus tasks, each starts and ends on a falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input elk_byte_t actual, input elk_byte_t expected,
		input string what);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s, read %h, expected %h", $time, what, actual, expected);
			$display("TEST FAILED");
			$fatal(1, "Read data mismatch");
		end
	endtask

	// Address for one cycle, data checked at the next falling edge
	task automatic read_check(input elk_addr_t a, input string what);
		cpu_addr = a;
		@(negedge clk_sys);
		check_value(cpu_rdata, expected_read(a), $sformatf("%s at %h", what, a));
	endtask

	task automatic cpu_write(input elk_addr_t a, input elk_byte_t d);
		cpu_addr  = a;
		cpu_wdata = d;
		cpu_we_n  = 1'b0;
		@(negedge clk_sys);
		cpu_we_n = 1'b1;
		model_write(a, d);
		// Registered strobe returns high
		@(negedge clk_sys);
	endtask

	// One download byte, caller holds load_en
	task automatic load_rom_byte(input rom_addr_t la, input elk_byte_t d);
		load_wr    = 1'b1;
		load_index = ROM_LOAD_INDEX;
		load_addr  = la;
		load_data  = d;
		@(negedge clk_sys);
		load_wr = 1'b0;
		rom_model[la] = d;
	endtask

	// Download strobe that must not reach the ROM
	task automatic stray_load(input logic en, input elk_byte_t idx, input rom_addr_t la,
		input elk_byte_t d);
		load_en    = en;
		load_wr    = 1'b1;
		load_index = idx;
		load_addr  = la;
		load_data  = d;
		@(negedge clk_sys);
		load_wr    = 1'b0;
		load_en    = 1'b0;
		load_index = ROM_LOAD_INDEX;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_unmapped_after_reset();
		logic [4:0] holes [0:8] = '{5'b0_00_00, 5'b0_00_01, 5'b0_00_10, 5'b0_00_11,
			5'b0_01_01, 5'b0_01_10, 5'b0_01_11, 5'b1_10_00, 5'b1_11_01};
		check_value(cpu_rdata, 8'h00, "Read data right after reset");
		for (int i = 0; i < 9; i++) begin
			read_check({holes[i], rand_offset()}, "Unmapped read");
		end
	endtask

	task automatic test_rom_load();
		rom_addr_t la;
		logic [13:0] off;
		load_en = 1'b1;
		for (int s = 0; s < 7; s++) begin
			// Both ends of the slot plus two random offsets
			for (int k = 0; k < 4; k++) begin
				if (k == 0) begin
					off = 14'h0000;
				end else if (k == 1) begin
					off = 14'h3fff;
				end else begin
					off = rand_offset();
				end
				la = {3'(s), off};
				load_rom_byte(la, rand_byte());
				loaded_rom.push_back(la);
			end
		end
		load_en = 1'b0;
		for (int i = 0; i < loaded_rom.size(); i++) begin
			la = loaded_rom[i];
			read_check(rom_cpu_addr(la, 1'b0), "ROM read");
			if (la[16:14] == 3'd1 || la[16:14] == 3'd2) begin
				read_check(rom_cpu_addr(la, 1'b1), "ROM alias read");
			end
		end
	endtask

	task automatic test_ram_write();
		elk_addr_t a;
		for (int b = 0; b < 8; b++) begin
			for (int k = 0; k < 3; k++) begin
				a = ram_cpu_addr(3'(b), rand_offset());
				cpu_write(a, rand_byte());
				read_check(a, "RAM read after write");
				written_ram.push_back(a);
			end
		end
		// Second pass catches writes landing in the wrong bank
		for (int i = 0; i < written_ram.size(); i++) begin
			read_check(written_ram[i], "RAM read back");
		end
	endtask

	task automatic test_write_strobe();
		elk_addr_t a;
		elk_byte_t first;
		logic [13:0] off;
		off   = rand_offset();
		a     = ram_cpu_addr(3'd5, off);
		first = rand_byte();
		// Strobe held low while the data keeps changing
		cpu_addr  = a;
		cpu_wdata = first;
		cpu_we_n  = 1'b0;
		for (int i = 0; i < 4; i++) begin
			@(negedge clk_sys);
			cpu_wdata = rand_byte();
		end
		cpu_we_n = 1'b1;
		model_write(a, first);
		@(negedge clk_sys);
		read_check(a, "RAM after held strobe");
		// Known byte in bank 0, where the old design aliased the hole
		cpu_write(ram_cpu_addr(3'd0, off), 8'h5a);
		a = {5'b0_10_00, off};
		cpu_write(a, 8'hc3);
		read_check(a, "ROM after CPU write");
		read_check(ram_cpu_addr(3'd0, off), "RAM after ROM window write");
		a = {5'b1_10_00, off};
		cpu_write(a, 8'ha5);
		read_check(a, "Hole after write");
		read_check(ram_cpu_addr(3'd0, off), "RAM bank 0 after hole write");
		// Low bits of this hole window point at bank 5
		a = {5'b1_11_01, off};
		cpu_write(a, 8'h3c);
		read_check(a, "Hole after write");
		read_check(ram_cpu_addr(3'd5, off), "RAM bank 5 after hole write");
	endtask

	task automatic test_stray_load();
		rom_addr_t la;
		la = loaded_rom[5];
		// CPU side points at the same byte, so the ROM port sees it in either mode
		cpu_addr = rom_cpu_addr(la, 1'b0);
		stray_load(1'b0, ROM_LOAD_INDEX, la, ~rom_model[la]);
		stray_load(1'b1, 8'd1, la, ~rom_model[la]);
		stray_load(1'b1, 8'd3, la, ~rom_model[la]);
		read_check(rom_cpu_addr(la, 1'b0), "ROM after ignored download");
		read_check(rom_cpu_addr(la, 1'b1), "ROM alias after ignored download");
	endtask

	// New address every cycle, one access in flight
	task automatic test_alternating();
		for (int i = 0; i < loaded_rom.size(); i++) begin
			read_check(rom_cpu_addr(loaded_rom[i], i[0]), "Alternating ROM read");
			read_check(written_ram[i % written_ram.size()], "Alternating RAM read");
		end
	endtask

	initial begin
		arst_n     = 1'b0;
		cpu_addr   = '0;
		cpu_we_n   = 1'b1;
		cpu_wdata  = '0;
		load_en    = 1'b0;
		load_wr    = 1'b0;
		load_index = ROM_LOAD_INDEX;
		load_addr  = '0;
		load_data  = '0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		arst_n = 1'b1;
		test_unmapped_after_reset();
		test_rom_load();
		test_ram_write();
		test_write_strobe();
		test_stray_load();
		test_alternating();
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== elk_mem.f ====
verilog/elk_mem_pkg.sv
verilog/elk_mem_decode.sv
verilog/elk_mem_store.sv
verilog/elk_mem_readback.sv
verilog/elk_mem_top.sv
test/elk_mem_chk.sv
test/tb_elk_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the Electron memory testbench with Verilator and run it

set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert --top-module tb_elk_mem -f elk_mem.f

# Simulator exit status is left to the log search below
./obj_dir/Vtb_elk_mem > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi

if ! grep -q "TEST PASSED" "$LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi

exit 0
